//--- src.f
+incdir+src
src/openadc_pkg.sv
src/openadc_cfg_if.sv
src/heartbeat_timer.sv
src/extclk_monitor.sv
src/adc_level_trigger.sv
src/openadc_ctrl.sv
src/openadc_top.sv
bench/tb_clock.sv
bench/openadc_tb.sv

//--- bench/openadc_tb.sv
`include "openadc_settings.svh"

module openadc_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CYCLE_LIMIT = 12000;
   localparam int WINDOW      = 256;   // cycles per measurement window

   logic                       clk_usb;
   logic                       reset;
   logic [`REG_ADDR_WIDTH-1:0] reg_address_i;
   logic [`BYTECNT_WIDTH-1:0]  reg_bytecnt_i;
   logic [7:0]                 reg_datai_i;
   logic                       reg_read_i;
   logic                       reg_write_i;
   logic [7:0]                 reg_datao_o;
   logic [`ADC_WIDTH-1:0]      adc_data_i;
   logic                       ext_clk_i;
   logic                       pll_status_i;
   logic                       led_armed_o;
   logic                       led_capture_o;
   logic                       freq_measure_o;
   logic                       trigger_adc_o;
   logic                       amp_gain_o;

   int     n_pass     = 0;
   int     n_fail     = 0;
   int     test_fails = 0;
   int     cycles     = 0;
   int     ext_period = 0;  // in clk_usb cycles, 0 stops the clock
   int     ext_phase  = 0;
   integer seed       = 32'h4625_1d4a;

   tb_clock tb_clock_inst (
      .clk_usb_o (clk_usb),
      .reset_o   (reset)
   );

   openadc_top openadc_top_inst (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .reg_address_i  (reg_address_i),
      .reg_bytecnt_i  (reg_bytecnt_i),
      .reg_datai_i    (reg_datai_i),
      .reg_read_i     (reg_read_i),
      .reg_write_i    (reg_write_i),
      .reg_datao_o    (reg_datao_o),
      .adc_data_i     (adc_data_i),
      .ext_clk_i      (ext_clk_i),
      .pll_status_i   (pll_status_i),
      .led_armed_o    (led_armed_o),
      .led_capture_o  (led_capture_o),
      .freq_measure_o (freq_measure_o),
      .trigger_adc_o  (trigger_adc_o),
      .amp_gain_o     (amp_gain_o)
   );

   assert property (@(posedge clk_usb) disable iff (reset) trigger_adc_o |=> !trigger_adc_o)
      else begin
         n_fail++;
         $display("error @%0t: trigger_adc_o high for more than one cycle", $time);
      end

   assert property (@(posedge clk_usb) disable iff (reset) freq_measure_o |=> !freq_measure_o)
      else begin
         n_fail++;
         $display("error @%0t: freq_measure_o high for more than one cycle", $time);
      end

   // external clock as a data input
   always begin
      @(posedge clk_usb);
      #10ns;
      if (ext_period > 0) begin
         ext_phase = (ext_phase + 1 >= ext_period) ? 0 : ext_phase + 1;
         ext_clk_i = (ext_phase < ext_period / 2);
      end
   end

   initial begin
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk_usb);
         cycles++;
      end
      $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("=== FAIL ===");
      $finish;
   end

   task automatic step();
      @(posedge clk_usb);
      #10ns;
   endtask

   task automatic check(input bit ok, input string msg);
      assert (ok) n_pass++;
      else begin
         n_fail++;
         $display("error @%0t: %s", $time, msg);
      end
   endtask

   task automatic end_test(input string name);
      if (n_fail == test_fails)
         $display("test %s: ok", name);
      else
         $display("test %s: failed with %0d errors", name, n_fail - test_fails);
      test_fails = n_fail;
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [6:0] idx,
                            input logic [7:0] data);
      reg_address_i = addr;
      reg_bytecnt_i = idx;
      reg_datai_i   = data;
      reg_write_i   = 1'b1;
      step();                 // takes effect at this edge
      reg_write_i   = 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, input logic [6:0] idx,
                           output logic [7:0] data);
      reg_address_i = addr;
      reg_bytecnt_i = idx;
      reg_read_i    = 1'b1;
      #30ns;                  // mid cycle, comb output settled
      data = reg_datao_o;
      step();
      reg_read_i    = 1'b0;
   endtask

   task automatic expect_reg(input logic [7:0] addr, input logic [6:0] idx,
                             input logic [7:0] exp, input string name);
      logic [7:0] data;
      read_reg(addr, idx, data);
      check(data === exp,
            $sformatf("%s byte %0d read %02h, expected %02h", name, idx, data, exp));
   endtask

   task automatic wait_strobe(output int waited);
      waited = 0;
      do begin
         step();
         waited++;
      end while (!freq_measure_o && waited < 600);
      check(freq_measure_o === 1'b1, "freq_measure_o did not pulse within 600 cycles");
   endtask

   task automatic wait_windows(input int count);
      int gap;
      repeat (count) wait_strobe(gap);
   endtask

   task automatic poll_status(input int bit_idx, input bit value, input int limit);
      logic [7:0] data;
      int         tries;
      tries = 0;
      do begin
         read_reg(`ADDR_STATUS, 0, data);
         tries++;
      end while (data[bit_idx] !== value && tries < limit);
      check(data[bit_idx] === value,
            $sformatf("status bit %0d did not become %0b within %0d reads",
                      bit_idx, value, limit));
   endtask

   // trigger rule, msb of the level picks the direction
   function automatic bit passes_level(input logic [11:0] value, input logic [11:0] level);
      if (level[11])
         return value > level;
      return value < level;
   endfunction

   task automatic reset_values();
      check(!trigger_adc_o && !freq_measure_o && !amp_gain_o, "outputs not low after reset");
      expect_reg(`ADDR_GAIN, 0, 8'h00, "gain");
      expect_reg(`ADDR_SETTINGS, 0, 8'h00, "settings");
      expect_reg(`ADDR_STATUS, 0, 8'h00, "status");
      for (int i = 0; i < 4; i++) begin
         if (i < 2)
            expect_reg(`ADDR_TRIG_LEVEL, 7'(i), 8'h00, "trigger level");
         expect_reg(`ADDR_EXTCLK_FREQ, 7'(i), 8'h00, "extclk freq");
         expect_reg(`ADDR_EXTCLK_LIMIT, 7'(i), 8'h00, "extclk limit");
      end
      write_reg(`ADDR_GAIN, 0, 8'hA5);
      write_reg(`ADDR_TRIG_LEVEL, 0, 8'h3C);
      write_reg(`ADDR_TRIG_LEVEL, 1, 8'h0B);  // only a nibble is stored
      for (int i = 0; i < 4; i++)
         write_reg(`ADDR_EXTCLK_LIMIT, 7'(i), 8'(8'h11 * (i + 1)));
      expect_reg(`ADDR_GAIN, 0, 8'hA5, "gain");
      expect_reg(`ADDR_TRIG_LEVEL, 0, 8'h3C, "trigger level");
      expect_reg(`ADDR_TRIG_LEVEL, 1, 8'h0B, "trigger level");
      for (int i = 0; i < 4; i++)
         expect_reg(`ADDR_EXTCLK_LIMIT, 7'(i), 8'(8'h11 * (i + 1)), "extclk limit");
      reg_address_i = `ADDR_GAIN;
      #30ns;
      check(reg_datao_o === 8'h00, "read data not zero with reg_read_i low");
      step();
   endtask

   task automatic gain_duty(input logic [7:0] gain);
      int highs;
      highs = 0;
      write_reg(`ADDR_GAIN, 0, gain);
      step();                 // new gain in the accumulator from here
      repeat (256) begin
         if (amp_gain_o)
            highs++;
         step();
      end
      check(highs == gain, $sformatf("gain %02h gave %0d high cycles in 256", gain, highs));
   endtask

   task automatic strobe_period();
      int gap;
      wait_strobe(gap);       // line up on a pulse first
      repeat (4) begin
         wait_strobe(gap);
         check(gap == WINDOW, $sformatf("freq_measure_o gap of %0d cycles", gap));
      end
   endtask

   task automatic run_trigger(input logic [11:0] level);
      logic [11:0] value;
      logic [7:0]  status;
      int          first;
      int          pulses;
      int          n;
      first  = -1;
      pulses = 0;
      adc_data_i = level;     // equal to the level, never passes
      write_reg(`ADDR_TRIG_LEVEL, 0, level[7:0]);
      write_reg(`ADDR_TRIG_LEVEL, 1, {4'h0, level[11:8]});
      write_reg(`ADDR_SETTINGS, 0, 8'h10);   // adc source, disarmed
      write_reg(`ADDR_SETTINGS, 0, 8'h11);   // arm
      for (n = 0; n < 400; n++) begin
         if (trigger_adc_o) begin
            pulses++;
            check(first >= 0 && n == first + 3,
                  $sformatf("trigger at cycle %0d, first passing sample at %0d", n, first));
         end
         if (first >= 0 && n >= first + 20)
            break;
         value      = 12'($random(seed));
         adc_data_i = value;
         if (first < 0 && passes_level(value, level))
            first = n;
         step();
      end
      check(first >= 0, $sformatf("no sample passed level %03h in 400 cycles", level));
      check(pulses == 1, $sformatf("level %03h gave %0d trigger pulses", level, pulses));
      read_reg(`ADDR_STATUS, 0, status);
      check(status[1:0] == 2'b10, $sformatf("status %02h after trigger", status));
   endtask

   task automatic measure_ext(input int period);
      logic [7:0] data;
      int         freq;
      ext_period = period;
      wait_windows(3);
      step();                 // freq loads the cycle after the strobe
      freq = 0;
      for (int i = 0; i < 4; i++) begin
         read_reg(`ADDR_EXTCLK_FREQ, 7'(i), data);
         freq = freq | (int'(data) << (8 * i));
      end
      check(freq >= WINDOW / period - 1 && freq <= WINDOW / period + 1,
            $sformatf("period %0d gave frequency %0d, expected %0d",
                      period, freq, WINDOW / period));
   endtask

   task automatic extclk_frequency();
      write_reg(`ADDR_EXTCLK_LIMIT, 0, 8'h08);
      for (int i = 1; i < 4; i++)
         write_reg(`ADDR_EXTCLK_LIMIT, 7'(i), 8'h00);
      write_reg(`ADDR_SETTINGS, 0, 8'h08);   // monitor off while clocks settle
      measure_ext(5);
      measure_ext(8);
   endtask

   task automatic clock_change();
      logic [7:0] status;
      write_reg(`ADDR_SETTINGS, 0, 8'h01);   // armed, so the normal leds differ
      wait_windows(2);
      step();
      step();
      read_reg(`ADDR_STATUS, 0, status);
      check(status[2] === 1'b0, "change flag set with a steady external clock");
      ext_period = 3;
      poll_status(2, 1'b1, 1000);
      check(led_armed_o === led_capture_o, "leds differ while the change flag is set");
      write_reg(`ADDR_SETTINGS, 0, 8'h08);
      poll_status(2, 1'b0, 4);
      ext_period = 0;
      ext_clk_i  = 1'b0;
   endtask

   initial begin
      reg_address_i = '0;
      reg_bytecnt_i = '0;
      reg_datai_i   = '0;
      reg_read_i    = 1'b0;
      reg_write_i   = 1'b0;
      adc_data_i    = '0;
      ext_clk_i     = 1'b0;
      pll_status_i  = 1'b0;
      step();
      while (reset)
         step();

      reset_values();
      end_test("1 reset values and readback");
      gain_duty(8'h00);
      gain_duty(8'h5B);
      gain_duty(8'hFF);
      end_test("2 gain pwm duty");
      strobe_period();
      end_test("3 freq_measure period");
      run_trigger(12'h200);
      run_trigger(12'hE00);
      end_test("4 level trigger");
      extclk_frequency();
      end_test("5 extclk frequency");
      clock_change();
      end_test("6 extclk change flag");

      $display("checks passed: %0d, failed: %0d", n_pass, n_fail);
      if (n_fail == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

//--- bench/tb_clock.sv
module tb_clock (
   output logic clk_usb_o,
   output logic reset_o
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int RESET_CYCLES = 4;

   initial begin
      clk_usb_o = 1'b0;
      forever #50ns clk_usb_o = ~clk_usb_o; // 100 ns period
   end

   // released right at the edge, so the first stimulus sees it low
   initial begin
      reset_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_usb_o);
      reset_o <= 1'b0;
   end

endmodule

//--- src/openadc_top.sv
`include "openadc_settings.svh"

module openadc_top (
   input  logic                       clk_usb,
   input  logic                       reset,

   // register port
   input  logic [`REG_ADDR_WIDTH-1:0] reg_address_i,
   input  logic [`BYTECNT_WIDTH-1:0]  reg_bytecnt_i,
   input  logic [7:0]                 reg_datai_i,
   input  logic                       reg_read_i,
   input  logic                       reg_write_i,
   output logic [7:0]                 reg_datao_o,

   input  logic [`ADC_WIDTH-1:0]      adc_data_i,
   input  logic                       ext_clk_i,    // sampled as data
   input  logic                       pll_status_i,

   output logic                       led_armed_o,
   output logic                       led_capture_o,
   output logic                       freq_measure_o,
   output logic                       trigger_adc_o,
   output logic                       amp_gain_o
);

   logic flash;
   logic timer_led;

   openadc_cfg_if cfg_if ();

   heartbeat_timer heartbeat_timer_inst (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .freq_measure_o (freq_measure_o),
      .flash_o        (flash),
      .timer_led_o    (timer_led)
   );

   openadc_ctrl openadc_ctrl_inst (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .reg_address_i  (reg_address_i),
      .reg_bytecnt_i  (reg_bytecnt_i),
      .reg_datai_i    (reg_datai_i),
      .reg_read_i     (reg_read_i),
      .reg_write_i    (reg_write_i),
      .pll_status_i   (pll_status_i),
      .freq_measure_i (freq_measure_o),
      .flash_i        (flash),
      .timer_led_i    (timer_led),
      .cfg            (cfg_if.ctrl),
      .reg_datao_o    (reg_datao_o),
      .led_armed_o    (led_armed_o),
      .led_capture_o  (led_capture_o),
      .amp_gain_o     (amp_gain_o)
   );

   extclk_monitor extclk_monitor_inst (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .ext_clk_i      (ext_clk_i),
      .freq_measure_i (freq_measure_o),
      .cfg            (cfg_if.monitor)
   );

   adc_level_trigger adc_level_trigger_inst (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .adc_data_i     (adc_data_i),
      .cfg            (cfg_if.trigger),
      .trigger_adc_o  (trigger_adc_o)
   );

endmodule

//--- src/openadc_ctrl.sv
`include "openadc_settings.svh"

module openadc_ctrl (
   input  logic                      clk_usb,
   input  logic                      reset,
   input  logic [`REG_ADDR_WIDTH-1:0] reg_address_i,
   input  logic [`BYTECNT_WIDTH-1:0] reg_bytecnt_i,
   input  logic [7:0]                reg_datai_i,
   input  logic                      reg_read_i,
   input  logic                      reg_write_i,
   input  logic                      pll_status_i,
   input  logic                      freq_measure_i,
   input  logic                      flash_i,
   input  logic                      timer_led_i,
   openadc_cfg_if.ctrl               cfg,
   output logic [7:0]                reg_datao_o,
   output logic                      led_armed_o,
   output logic                      led_capture_o,
   output logic                      amp_gain_o
);

   localparam int FREQ_BYTES = `FREQ_WIDTH / 8;

   openadc_pkg::reg_addr_e  reg_addr;
   openadc_pkg::arm_state_e state;
   openadc_pkg::led_sel_e   led_sel;

   logic [7:0]             settings;
   logic [7:0]             gain;
   logic [`ADC_WIDTH-1:0]  trig_level;
   logic [`FREQ_WIDTH-1:0] limit;
   logic [15:0]            level_word;
   logic [7:0]             status;
   logic [7:0]             rd_byte;
   logic [8:0]             pwm_acc;
   logic                   byte_zero;
   logic                   settings_wr;
   logic                   arm_set;
   logic                   arm_clr;
   logic                   arm_start_q;
   logic                   window_q;
   logic                   change_flag;

   assign reg_addr    = openadc_pkg::reg_addr_e'(reg_address_i);
   assign byte_zero   = (reg_bytecnt_i == '0);
   assign settings_wr = reg_write_i && byte_zero && (reg_addr == openadc_pkg::REG_SETTINGS);
   assign arm_set     = settings_wr && reg_datai_i[0] && !settings[0]; // 0 -> 1 only
   assign arm_clr     = settings_wr && !reg_datai_i[0];

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         settings   <= '0;
         gain       <= '0;
         trig_level <= '0;
         limit      <= '0;
      end
      else if (reg_write_i) begin
         case (reg_addr)
            openadc_pkg::REG_SETTINGS: if (byte_zero) settings <= reg_datai_i;
            openadc_pkg::REG_GAIN:     if (byte_zero) gain <= reg_datai_i;
            openadc_pkg::REG_TRIG_LEVEL: begin
               if (byte_zero)
                  trig_level[7:0] <= reg_datai_i;
               else if (reg_bytecnt_i == 1)
                  trig_level[`ADC_WIDTH-1:8] <= reg_datai_i[`ADC_WIDTH-9:0]; // upper nibble
            end
            openadc_pkg::REG_EXTCLK_LIMIT: begin
               if (reg_bytecnt_i < FREQ_BYTES)
                  limit[8*reg_bytecnt_i[1:0] +: 8] <= reg_datai_i; // little endian
            end
            default: ;
         endcase
      end
   end

   // arm machine
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         state       <= openadc_pkg::ARM_IDLE;
         arm_start_q <= 1'b0;
      end
      else begin
         arm_start_q <= 1'b0;
         case (state)
            openadc_pkg::ARM_IDLE: begin
               if (arm_set) begin
                  state       <= openadc_pkg::ARM_ARMED;
                  arm_start_q <= 1'b1;
               end
            end
            openadc_pkg::ARM_ARMED: begin
               if (arm_clr)
                  state <= openadc_pkg::ARM_IDLE;
               else if (cfg.trigger_fire)
                  state <= openadc_pkg::ARM_TRIGGERED;
            end
            openadc_pkg::ARM_TRIGGERED: if (arm_clr) state <= openadc_pkg::ARM_IDLE;
            default: state <= openadc_pkg::ARM_IDLE;
         endcase
      end
   end

   // monitor flag is picked up right after each window closes
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         window_q    <= 1'b0;
         change_flag <= 1'b0;
      end
      else begin
         window_q <= freq_measure_i;
         if (settings[3])
            change_flag <= 1'b0;
         else if (window_q)
            change_flag <= cfg.extclk_change;
      end
   end

   // gain pwm, carry out is the output
   always_ff @(posedge clk_usb) begin
      if (reset)
         pwm_acc <= '0;
      else
         pwm_acc <= pwm_acc[7:0] + gain;
   end
   assign amp_gain_o = pwm_acc[8];

   assign status     = {4'b0, pll_status_i, change_flag,
                        state == openadc_pkg::ARM_TRIGGERED,
                        state == openadc_pkg::ARM_ARMED};
   assign level_word = 16'(trig_level);

   always_comb begin
      rd_byte = '0;
      if (reg_read_i) begin
         case (reg_addr)
            openadc_pkg::REG_SETTINGS: if (byte_zero) rd_byte = settings;
            openadc_pkg::REG_STATUS:   if (byte_zero) rd_byte = status;
            openadc_pkg::REG_GAIN:     if (byte_zero) rd_byte = gain;
            openadc_pkg::REG_TRIG_LEVEL: begin
               if (reg_bytecnt_i < 2)
                  rd_byte = level_word[8*reg_bytecnt_i[0] +: 8];
            end
            openadc_pkg::REG_EXTCLK_FREQ: begin
               if (reg_bytecnt_i < FREQ_BYTES)
                  rd_byte = cfg.extclk_freq[8*reg_bytecnt_i[1:0] +: 8];
            end
            openadc_pkg::REG_EXTCLK_LIMIT: begin
               if (reg_bytecnt_i < FREQ_BYTES)
                  rd_byte = limit[8*reg_bytecnt_i[1:0] +: 8];
            end
            default: rd_byte = '0;
         endcase
      end
   end
   assign reg_datao_o = rd_byte;

   assign led_sel = openadc_pkg::led_sel_e'(settings[2:1]);

   always_comb begin
      led_armed_o   = status[0];
      led_capture_o = status[1];
      if (change_flag) begin
         // clock changed, flash both until cleared
         led_armed_o   = flash_i;
         led_capture_o = flash_i;
      end
      else begin
         case (led_sel)
            openadc_pkg::LED_NORMAL: ;
            openadc_pkg::LED_TIMER: begin
               led_armed_o   = timer_led_i;
               led_capture_o = flash_i;
            end
            openadc_pkg::LED_EXTCLK: begin
               led_armed_o   = cfg.ext_clk_level;
               led_capture_o = cfg.extclk_change; // raw flag, ahead of status
            end
            openadc_pkg::LED_GAIN: begin
               led_armed_o   = pwm_acc[8];
               led_capture_o = status[0];
            end
         endcase
      end
   end

   assign cfg.arm_start       = arm_start_q;
   assign cfg.data_source_sel = settings[4];
   assign cfg.monitor_disable = settings[3];
   assign cfg.trigger_level   = trig_level;
   assign cfg.extclk_limit    = limit;

endmodule

//--- src/adc_level_trigger.sv
`include "openadc_settings.svh"

module adc_level_trigger (
   input  logic                  clk_usb,
   input  logic                  reset,
   input  logic [`ADC_WIDTH-1:0] adc_data_i,
   openadc_cfg_if.trigger        cfg,
   output logic                  trigger_adc_o
);

   logic [`ADC_WIDTH-1:0] pattern_cnt;  // test ramp
   logic [`ADC_WIDTH-1:0] sample_pre;
   logic [`ADC_WIDTH-1:0] sample;
   logic                  allowed;
   logic                  level_hit;
   logic                  fire;

   always_ff @(posedge clk_usb) begin
      if (reset)
         pattern_cnt <= '0;
      else
         pattern_cnt <= pattern_cnt + 1'b1;
   end

   // two sample stages ahead of the compare
   always_ff @(posedge clk_usb) begin
      sample_pre <= cfg.data_source_sel ? adc_data_i : pattern_cnt;
      sample     <= sample_pre;
   end

   // msb of the level picks the direction
   assign level_hit = cfg.trigger_level[`ADC_WIDTH-1] ? (sample > cfg.trigger_level)
                                                      : (sample < cfg.trigger_level);
   assign fire = allowed & level_hit;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         allowed       <= 1'b0;
         trigger_adc_o <= 1'b0;
      end
      else begin
         trigger_adc_o <= fire;
         if (fire)
            allowed <= 1'b0;   // single shot per arm
         else if (cfg.arm_start)
            allowed <= 1'b1;
      end
   end

   assign cfg.trigger_fire = trigger_adc_o;

endmodule

//--- src/extclk_monitor.sv
`include "openadc_settings.svh"

module extclk_monitor (
   input  logic          clk_usb,
   input  logic          reset,
   input  logic          ext_clk_i,
   input  logic          freq_measure_i,
   openadc_cfg_if.monitor cfg
);

   logic [1:0]             ext_sync;  // two flop synchronizer
   logic                   ext_prev;
   logic                   ext_rise;
   logic [`FREQ_WIDTH-1:0] edge_cnt;
   logic [`FREQ_WIDTH-1:0] freq;
   logic [`FREQ_WIDTH-1:0] freq_diff;
   logic                   change;

   assign ext_rise = ext_sync[1] & ~ext_prev;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ext_sync <= '0;
         ext_prev <= 1'b0;
      end
      else begin
         ext_sync <= {ext_sync[0], ext_clk_i};
         ext_prev <= ext_sync[1];
      end
   end

   // edges counted over one window, then latched
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         edge_cnt <= '0;
         freq     <= '0;
      end
      else if (freq_measure_i) begin
         freq     <= edge_cnt;
         edge_cnt <= `FREQ_WIDTH'(ext_rise); // an edge here opens the next window
      end
      else if (ext_rise) begin
         edge_cnt <= edge_cnt + 1'b1;
      end
   end

   assign freq_diff = (freq > edge_cnt) ? freq - edge_cnt : edge_cnt - freq;

   // sticky until monitoring is switched off
   always_ff @(posedge clk_usb) begin
      if (reset)
         change <= 1'b0;
      else if (cfg.monitor_disable)
         change <= 1'b0;
      else if (freq_measure_i && (freq != '0) && (freq_diff > cfg.extclk_limit))
         change <= 1'b1;
   end

   assign cfg.extclk_freq   = freq;
   assign cfg.extclk_change = change;
   assign cfg.ext_clk_level = ext_sync[1];

endmodule

//--- src/heartbeat_timer.sv
`include "openadc_settings.svh"

module heartbeat_timer (
   input  logic clk_usb,
   input  logic reset,
   output logic freq_measure_o,
   output logic flash_o,
   output logic timer_led_o
);

   logic [`TIMER_WIDTH-1:0] timer;
   logic                    window_q; // last value of the window bit

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         timer          <= '0;
         window_q       <= 1'b0;
         freq_measure_o <= 1'b0;
      end
      else begin
         timer    <= timer + 1'b1;
         window_q <= timer[`WINDOW_BIT];
         // every toggle of the window bit closes a window
         freq_measure_o <= (timer[`WINDOW_BIT] != window_q);
      end
   end

   // slow blink, only refreshed in the upper half of the timer period
   always_ff @(posedge clk_usb) begin
      if (reset)
         flash_o <= 1'b0;
      else if (timer[`FLASH_GATE_BIT])
         flash_o <= ~timer[`FLASH_BIT];
   end

   assign timer_led_o = timer[`LED_TIMER_BIT];

endmodule

//--- src/openadc_cfg_if.sv
`include "openadc_settings.svh"

interface openadc_cfg_if;

   // from the control module
   logic                   arm_start;        // one cycle, on entering armed
   logic                   data_source_sel;  // 1 = adc input, 0 = counter pattern
   logic [`ADC_WIDTH-1:0]  trigger_level;
   logic                   monitor_disable;
   logic [`FREQ_WIDTH-1:0] extclk_limit;

   // back from the datapath
   logic                   trigger_fire;
   logic [`FREQ_WIDTH-1:0] extclk_freq;      // edges per window
   logic                   extclk_change;    // sticky
   logic                   ext_clk_level;    // after the synchronizer

   modport ctrl (
      output arm_start,
      output data_source_sel,
      output trigger_level,
      output monitor_disable,
      output extclk_limit,
      input  trigger_fire,
      input  extclk_freq,
      input  extclk_change,
      input  ext_clk_level
   );

   modport trigger (
      input  arm_start,
      input  data_source_sel,
      input  trigger_level,
      output trigger_fire
   );

   modport monitor (
      input  monitor_disable,
      input  extclk_limit,
      output extclk_freq,
      output extclk_change,
      output ext_clk_level
   );

endinterface

//--- src/openadc_pkg.sv
`include "openadc_settings.svh"

package openadc_pkg;

   typedef enum logic [1:0] {
      ARM_IDLE      = 2'd0,
      ARM_ARMED     = 2'd1,
      ARM_TRIGGERED = 2'd2
   } arm_state_e;

   typedef enum logic [`REG_ADDR_WIDTH-1:0] {
      REG_GAIN         = `REG_ADDR_WIDTH'(`ADDR_GAIN),
      REG_SETTINGS     = `REG_ADDR_WIDTH'(`ADDR_SETTINGS),
      REG_STATUS       = `REG_ADDR_WIDTH'(`ADDR_STATUS),
      REG_TRIG_LEVEL   = `REG_ADDR_WIDTH'(`ADDR_TRIG_LEVEL),
      REG_EXTCLK_FREQ  = `REG_ADDR_WIDTH'(`ADDR_EXTCLK_FREQ),
      REG_EXTCLK_LIMIT = `REG_ADDR_WIDTH'(`ADDR_EXTCLK_LIMIT)
   } reg_addr_e;

   // settings bits 2:1
   typedef enum logic [1:0] {LED_NORMAL, LED_TIMER, LED_EXTCLK, LED_GAIN} led_sel_e;

endpackage

//--- src/openadc_settings.svh
`ifndef OPENADC_SETTINGS_SVH
`define OPENADC_SETTINGS_SVH

// datapath widths
`define ADC_WIDTH         12
`define REG_ADDR_WIDTH    8
`define BYTECNT_WIDTH     7
`define FREQ_WIDTH        32

// heartbeat timer, 2**WINDOW_BIT cycles per measurement window
`define TIMER_WIDTH       14
`define WINDOW_BIT        8
`define FLASH_BIT         11
`define FLASH_GATE_BIT    13
`define LED_TIMER_BIT     12

// register map
`define ADDR_GAIN         0
`define ADDR_SETTINGS     1
`define ADDR_STATUS       2
`define ADDR_TRIG_LEVEL   3
`define ADDR_EXTCLK_FREQ  5
`define ADDR_EXTCLK_LIMIT 6

`endif
